// File: zxKeyboard.f
+incdir+verif
common/zxKeyPkg.sv
common/keyEventIf.sv
ps2/ps2Receiver.sv
hdl/keyDecode.sv
hdl/keyMatrix.sv
hdl/rowReadout.sv
hdl/zxKeyboardTop.sv
verif/zxKeyboardTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the keyboard testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module zxKeyboardTb \
    -f zxKeyboard.f \
    --Mdir obj_dir \
    -o zxKeyboardSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/zxKeyboardSim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "test passed" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// File: verif/keyboardModel.svh
/*
 * Testbench keyboard model
 * Prefix tracking, expected key matrix, port FE row rule,
 * PS/2 frame driver and random number source
 */
`ifndef KEYBOARD_MODEL_SVH
`define KEYBOARD_MODEL_SVH

localparam int HalfPeriod = 20;                 // clk cycles per ps2Clk phase

// Letter and digit make codes, the random pool
localparam logic [7:0] LetterCodes [36] = '{
    8'h1A, 8'h22, 8'h21, 8'h2A, 8'h1C, 8'h1B, 8'h23, 8'h2B, 8'h34,
    8'h15, 8'h1D, 8'h24, 8'h2D, 8'h2C, 8'h16, 8'h1E, 8'h26, 8'h25,
    8'h2E, 8'h45, 8'h46, 8'h3E, 8'h3D, 8'h36, 8'h4D, 8'h44, 8'h43,
    8'h3C, 8'h35, 8'h4B, 8'h42, 8'h3B, 8'h33, 8'h3A, 8'h31, 8'h32
};

zxKeyPkg::keyMatrix_t modelKeys;                // Expected matrix, 0 = pressed
logic                 modelReleased;            // Break prefix pending
logic                 modelExtended;            // E0 prefix pending
logic [31:0]          lcgState;                 // Generator state

// Numerical Recipes constants
function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
endfunction

// One good byte through the prefix rules
function automatic void applyByte(input logic [7:0] code);
    zxKeyPkg::keyMatrix_t mask;
    if (code == 8'hE0) begin
        modelExtended = 1'b1;
    end else if (code == 8'hF0) begin
        modelReleased = 1'b1;
    end else begin
        mask = zxKeyPkg::scanToKeys(code, modelExtended);
        for (int r = 0; r < 8; r++)
            for (int c = 0; c < 5; c++)
                if (mask[r][c])
                    modelKeys[r][c] = modelReleased;    // Break leaves the key high
        modelReleased = 1'b0;                   // Any code ends the prefix run
        modelExtended = 1'b0;
    end
endfunction

// Bad frame, every key up and prefixes gone
function automatic void applyFrameError();
    modelKeys     = '1;
    modelReleased = 1'b0;
    modelExtended = 1'b0;
endfunction

// Port FE answer for an address
function automatic zxKeyPkg::keyRow_t expectRow(input logic [15:0] a);
    zxKeyPkg::keyRow_t row;
    logic [7:0]        lines;
    row   = 5'h1F;
    lines = a[15:8];
    for (int r = 0; r < 8; r++) begin
        if (lines[0] == 1'b0)
            row = row & modelKeys[r];           // Low line pulls its row in
        lines = lines >> 1;
    end
    return row;
endfunction

// One 11-bit frame, data set while ps2Clk is high
task automatic sendFrame(input logic [7:0] code, input logic corrupt);
    logic [10:0] bits;
    bits = {1'b1, (~^code) ^ corrupt, code, 1'b0};  // Stop, odd parity, data, start
    for (int i = 0; i < 11; i++) begin
        @(negedge clk);
        ps2Data = bits[0];
        bits    = bits >> 1;
        repeat (HalfPeriod) @(negedge clk);
        ps2Clk = 1'b0;                          // Keyboard samples here
        repeat (HalfPeriod) @(negedge clk);
        ps2Clk = 1'b1;
    end
    ps2Data = 1'b1;                             // Idle line
endtask

`endif

// File: verif/zxKeyboardTb.sv
/*
 * Keyboard subsystem testbench
 * Sends PS/2 frames, tracks the expected matrix and checks port FE reads
 */
`timescale 1ns/1ns

module zxKeyboardTb;

    localparam int ClkPeriod   = 4;
    localparam int FrameCycles = 11 * 2 * 20;   // One PS/2 frame in clk cycles
    localparam int FrameBudget = 128;           // More frames than all tests send
    localparam int WatchdogNs  = FrameBudget * FrameCycles * 2 * ClkPeriod;

    logic        clk = 1'b0;
    logic        reset;
    logic        ps2Clk;
    logic        ps2Data;
    logic [15:0] addr;
    logic [4:0]  keyRow;

    int testNum     = 0;
    int testErrors  = 0;
    int testsPassed = 0;
    int testsFailed = 0;
    int checkCount  = 0;

    `include "keyboardModel.svh"

    always #(ClkPeriod / 2) clk = ~clk;

    zxKeyboardTop zxKeyboardTop_inst (
        .clk     (clk),
        .reset   (reset),
        .ps2Clk  (ps2Clk),
        .ps2Data (ps2Data),
        .addr    (addr),
        .keyRow  (keyRow)
    );

    // ==================================================================
    // Checks and test bookkeeping
    // ==================================================================
    task automatic beginTest();
        testNum++;
        testErrors = 0;
    endtask

    task automatic finishTest(input string name);
        if (testErrors == 0) begin
            testsPassed++;
            $display("Test %0d %s: ok", testNum, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: %0d errors", testNum, name, testErrors);
        end
    endtask

    // Drive addr and compare on the next falling edge
    task automatic checkRow(input logic [15:0] a);
        zxKeyPkg::keyRow_t expected;
        @(negedge clk);
        addr = a;
        @(negedge clk);
        expected = expectRow(a);
        checkCount++;
        assert (keyRow == expected) else begin
            $display("Error at %0t ns: addr %h, expected keyRow %b, got %b",
                     $time, a, expected, keyRow);
            testErrors++;
        end
    endtask

    // Each row alone and then one random address
    task automatic checkRows();
        logic [31:0] rnd;
        logic [7:0]  select;
        select = 8'hFE;
        for (int r = 0; r < 8; r++) begin
            rnd = nextRandom();
            checkRow({select, rnd[15:8]});      // Random port byte below
            select = {select[6:0], 1'b1};
        end
        rnd = nextRandom();
        checkRow(rnd[31:16]);
    endtask

    // ==================================================================
    // Key stimulus
    // ==================================================================
    task automatic sendByte(input logic [7:0] code, input logic corrupt);
        sendFrame(code, corrupt);
        if (corrupt)
            applyFrameError();
        else
            applyByte(code);
        repeat (20) @(negedge clk);             // Margin past the 6 cycle path
        checkRows();
    endtask

    task automatic pressKey(input logic [7:0] code);
        sendByte(code, 1'b0);
    endtask

    task automatic releaseKey(input logic [7:0] code);
        sendByte(8'hF0, 1'b0);
        sendByte(code, 1'b0);
    endtask

    function automatic logic [7:0] randomLetter();
        logic [31:0] rnd;
        logic [5:0]  idx;
        rnd = nextRandom();
        idx = 6'(rnd[31:16] % 16'd36);
        return LetterCodes[idx];
    endfunction

    // ==================================================================
    // Test sequence
    // ==================================================================
    initial begin
        logic [31:0] rnd;
        logic [7:0]  arrows [4];
        reset         = 1'b0;
        ps2Clk        = 1'b1;
        ps2Data       = 1'b1;
        addr          = 16'hFFFF;
        lcgState      = 32'h14f3_9565;
        modelKeys     = '1;
        modelReleased = 1'b0;
        modelExtended = 1'b0;
        arrows        = '{8'h6B, 8'h72, 8'h75, 8'h74};  // Left down up right
        repeat (10) @(negedge clk);
        reset = 1'b1;

        beginTest();                            // Nothing pressed after reset
        for (int i = 0; i < 32; i++) begin
            rnd = nextRandom();
            checkRow(rnd[31:16]);
        end
        checkRows();
        finishTest("reset state");

        beginTest();                            // Random make and break
        for (int i = 0; i < 24; i++) begin
            rnd = nextRandom();
            if (rnd[31])
                releaseKey(randomLetter());
            else
                pressKey(randomLetter());
        end
        finishTest("random letters");

        beginTest();
        pressKey(8'h66);                        // Backspace presses CAPS and 0
        releaseKey(8'h66);
        pressKey(8'h12);                        // Shift then Ctrl on CAPS
        pressKey(8'h14);
        releaseKey(8'h12);                      // Last event frees CAPS
        releaseKey(8'h14);
        foreach (arrows[i]) begin
            sendByte(8'hE0, 1'b0);
            sendByte(arrows[i], 1'b0);
            sendByte(8'hE0, 1'b0);
            releaseKey(arrows[i]);
        end
        pressKey(8'h6B);                        // Keypad 4 maps to no key
        finishTest("multi-key");

        beginTest();                            // Several rows at once
        for (int i = 0; i < 4; i++)
            pressKey(randomLetter());
        for (int i = 0; i < 16; i++) begin
            rnd = nextRandom();
            checkRow({rnd[23:16] & rnd[31:24], rnd[7:0]});
        end
        rnd = nextRandom();
        checkRow({8'hFF, rnd[7:0]});
        finishTest("row merge");

        beginTest();
        for (int i = 0; i < 3; i++)
            pressKey(randomLetter());
        sendByte(randomLetter(), 1'b1);         // Parity error drops all keys
        sendByte(8'hF0, 1'b0);
        sendByte(8'h22, 1'b1);                  // Clears the pending break
        pressKey(8'h1C);                        // So A goes down
        releaseKey(8'h1C);
        finishTest("frame error");

        beginTest();
        pressKey(randomLetter());
        pressKey(randomLetter());
        pressKey(8'h05);                        // F1
        pressKey(8'h76);                        // Escape
        pressKey(8'h7C);                        // Keypad star
        sendByte(8'hE0, 1'b0);
        sendByte(8'hF0, 1'b0);
        sendByte(8'h0D, 1'b0);                  // Tab eats both prefixes
        pressKey(8'h29);                        // Space goes down as a plain make
        finishTest("unmapped codes");

        $display("Tests: %0d passed, %0d failed, %0d row checks",
                 testsPassed, testsFailed, checkCount);
        if (testsFailed == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // Hang guard sized from the frame budget
    initial begin
        #(WatchdogNs);
        $display("Timeout: the tests did not finish within %0d ns", WatchdogNs);
        $display("test failed");
        $finish;
    end

endmodule

// File: hdl/zxKeyboardTop.sv
/*
 * ZX Spectrum keyboard subsystem
 * PS/2 receiver, scan code decoder, key matrix and port FE readout
 */
`timescale 1ns/1ns

module zxKeyboardTop (
    input  logic        clk,
    input  logic        reset,      // Active low, asynchronous
    input  logic        ps2Clk,     // Keyboard clock line
    input  logic        ps2Data,    // Keyboard data line
    input  logic [15:0] addr,       // CPU address bus
    output logic [4:0]  keyRow      // Key row for IN (FE)
);

    logic [7:0]           scanCode;
    logic                 scanReady;
    logic                 scanError;
    zxKeyPkg::keyMatrix_t keys;

    keyEventIf keyEvents ();        // Decoder to matrix

    ps2Receiver ps2Receiver_inst (
        .clk       (clk),
        .reset     (reset),
        .ps2Clk    (ps2Clk),
        .ps2Data   (ps2Data),
        .scanCode  (scanCode),
        .scanReady (scanReady),
        .scanError (scanError)
    );

    keyDecode keyDecode_inst (
        .clk       (clk),
        .reset     (reset),
        .scanCode  (scanCode),
        .scanReady (scanReady),
        .scanError (scanError),
        .events    (keyEvents.source)
    );

    keyMatrix keyMatrix_inst (
        .clk    (clk),
        .reset  (reset),
        .events (keyEvents.sink),
        .keys   (keys)
    );

    rowReadout rowReadout_inst (
        .keys   (keys),
        .addr   (addr),
        .keyRow (keyRow)
    );

endmodule

// File: hdl/rowReadout.sv
/*
 * Port FE row readout
 * ANDs every key row whose high address line is low,
 * all ones when no row is selected
 */
`timescale 1ns/1ns

module rowReadout (
    input  zxKeyPkg::keyMatrix_t keys,      // Current matrix
    input  logic [15:0]          addr,      // CPU address, rows on 15:8
    output zxKeyPkg::keyRow_t    keyRow     // Answer to IN (FE)
);

    // Low byte of the address carries the port, only the high byte
    // selects rows
    always_comb begin
        keyRow = '1;                                    // No row, no key
        for (int row = 0; row < 8; row++) begin
            if (!addr[8 + row])
                keyRow = keyRow & keys[row];            // Several rows merge
        end
    end

endmodule

// File: hdl/keyMatrix.sv
/*
 * Key matrix state
 * Holds the 40 active-low Spectrum key bits and applies key
 * events so that the last event on a key wins
 */
`timescale 1ns/1ns

module keyMatrix (
    input  logic                 clk,
    input  logic                 reset,     // Active low, asynchronous
    keyEventIf.sink              events,    // From the decoder
    output zxKeyPkg::keyMatrix_t keys       // 0 = key down
);

    // ==================================================================
    // State update
    // ==================================================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            keys <= '1;                                 // Nothing pressed
        end else if (events.valid) begin
            if (events.clearAll)
                keys <= '1;                             // Frame error drops all keys
            else if (events.pressed)
                keys <= keys & ~events.keyMask;         // Pull masked keys low
            else
                keys <= keys | events.keyMask;          // Let masked keys go
        end
    end

    // Shared keys such as CAPS follow whichever source spoke last,
    // so releasing either Shift lets CAPS go

    // Events from the decoder arrive as single-cycle strobes
    validOneCycle: assert property (@(posedge clk) disable iff (!reset)
        events.valid |=> !events.valid);

endmodule

// File: hdl/keyDecode.sv
/*
 * Scan code decoder
 * Follows the E0 and F0 prefixes and turns each complete code
 * into a key event for the matrix, frame errors become clear-all
 */
`timescale 1ns/1ns

module keyDecode (
    input  logic       clk,
    input  logic       reset,       // Active low, asynchronous
    input  logic [7:0] scanCode,    // Byte from the receiver
    input  logic       scanReady,   // Byte valid strobe
    input  logic       scanError,   // Frame error strobe
    keyEventIf.source  events       // Out to the key matrix
);

    // ==================================================================
    // Prefix state
    // ==================================================================
    logic                 released;     // F0 seen, next code is a break
    logic                 extended;     // E0 seen, next code is extended
    logic                 isExtended;   // Current byte is E0
    logic                 isRelease;    // Current byte is F0
    zxKeyPkg::keyMatrix_t scanMask;     // Keys hit by the current byte
    logic                 maskHit;      // Byte maps to at least one key

    always_comb begin
        isExtended = (scanCode == zxKeyPkg::ScanExtended);
        isRelease  = (scanCode == zxKeyPkg::ScanRelease);
        scanMask   = zxKeyPkg::scanToKeys(scanCode, extended);
        maskHit    = (scanMask != '0);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            released <= 1'b0;
            extended <= 1'b0;
        end else if (scanError) begin
            released <= 1'b0;                   // Broken frame, start clean
            extended <= 1'b0;
        end else if (scanReady) begin
            if (isExtended) begin
                extended <= 1'b1;
            end else if (isRelease) begin
                released <= 1'b1;
            end else begin
                released <= 1'b0;               // Code consumed the prefixes
                extended <= 1'b0;
            end
        end
    end

    // ==================================================================
    // Event generation
    // ==================================================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            events.valid <= 1'b0;
        end else begin
            // Errors always emit, codes only when mapped
            events.valid <= scanError
                          | (scanReady & ~isExtended & ~isRelease & maskHit);
        end
    end

    always_ff @(posedge clk) begin
        if (scanError) begin
            events.keyMask  <= '0;
            events.pressed  <= 1'b0;
            events.clearAll <= 1'b1;            // Release everything
        end else if (scanReady) begin
            events.keyMask  <= scanMask;
            events.pressed  <= ~released;       // Make unless F0 came first
            events.clearAll <= 1'b0;
        end
    end

    // A key event must touch at least one key
    maskNotEmpty: assert property (@(posedge clk) disable iff (!reset)
        (events.valid && !events.clearAll) |-> (events.keyMask != '0));

endmodule

// File: ps2/ps2Receiver.sv
/*
 * PS/2 receiver
 * Synchronizes the keyboard clock and data lines, shifts in
 * 11-bit frames on falling clock edges and checks start, odd
 * parity and stop before handing the byte on
 */
`timescale 1ns/1ns

module ps2Receiver (
    input  logic       clk,
    input  logic       reset,       // Active low, asynchronous
    input  logic       ps2Clk,      // Raw keyboard clock
    input  logic       ps2Data,     // Raw keyboard data
    output logic [7:0] scanCode,    // Received byte
    output logic       scanReady,   // One-cycle strobe for a good frame
    output logic       scanError    // One-cycle strobe for a bad frame
);

    // ==================================================================
    // Line synchronizers and edge detect
    // ==================================================================
    logic [zxKeyPkg::SyncStages-1:0] clkSync;   // ps2Clk shift chain
    logic [zxKeyPkg::SyncStages-1:0] dataSync;  // ps2Data shift chain
    logic                            clkPrev;   // Last synced clock level
    logic                            fallEdge;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            clkSync  <= '1;                     // Lines idle high
            dataSync <= '1;
            clkPrev  <= 1'b1;
        end else begin
            clkSync  <= {clkSync[zxKeyPkg::SyncStages-2:0], ps2Clk};
            dataSync <= {dataSync[zxKeyPkg::SyncStages-2:0], ps2Data};
            clkPrev  <= clkSync[zxKeyPkg::SyncStages-1];
        end
    end

    assign fallEdge = clkPrev & ~clkSync[zxKeyPkg::SyncStages-1];  // High then low

    // ==================================================================
    // Frame assembly
    // ==================================================================
    logic [zxKeyPkg::FrameBits-1:0]             frame;      // LSB is the start bit
    logic [$clog2(zxKeyPkg::FrameBits)-1:0]     bitCount;   // Bits taken so far
    logic [$clog2(zxKeyPkg::FrameTimeout)-1:0]  idleCount;  // Cycles since last edge
    logic                                       frameDone;  // Stop bit just shifted in
    logic                                       frameOk;

    always_ff @(posedge clk) begin
        if (fallEdge)
            frame <= {dataSync[zxKeyPkg::SyncStages-1], frame[zxKeyPkg::FrameBits-1:1]};
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            bitCount  <= '0;
            idleCount <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            if (fallEdge) begin
                idleCount <= '0;
                if (int'(bitCount) == zxKeyPkg::FrameBits - 1) begin
                    bitCount  <= '0;            // Stop bit completes the frame
                    frameDone <= 1'b1;
                end else begin
                    bitCount <= bitCount + 1'b1;
                end
            end else if (bitCount != '0) begin
                // Frames stalled mid-way are dropped quietly
                if (int'(idleCount) == zxKeyPkg::FrameTimeout - 1) begin
                    bitCount  <= '0;
                    idleCount <= '0;
                end else begin
                    idleCount <= idleCount + 1'b1;
                end
            end
        end
    end

    // Start low, odd parity over data and parity bit, stop high
    assign frameOk = ~frame[0] & (^frame[9:1]) & frame[10];

    // ==================================================================
    // Output strobes
    // ==================================================================
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            scanReady <= 1'b0;
            scanError <= 1'b0;
        end else begin
            scanReady <= frameDone & frameOk;
            scanError <= frameDone & ~frameOk;
        end
    end

    always_ff @(posedge clk) begin
        if (frameDone)
            scanCode <= frame[8:1];             // Data bits arrive LSB first
    end

    // A frame ends in a single strobe cycle
    strobesOneCycle: assert property (@(posedge clk) disable iff (!reset)
        (scanReady || scanError) |=> !(scanReady || scanError));

endmodule

// File: common/keyEventIf.sv
/*
 * Key event channel from the decoder to the key matrix
 * One-cycle strobe with a mask, a press level and a clear flag
 */
`timescale 1ns/1ns

interface keyEventIf;

    logic                valid;     // One-cycle event strobe
    zxKeyPkg::keyMatrix_t keyMask;  // Keys touched by this event
    logic                pressed;   // Make or break, taken with valid
    logic                clearAll;  // Release every key, taken with valid

    // Decoder side
    modport source (
        output valid, keyMask, pressed, clearAll
    );

    // Matrix side, no back-pressure
    modport sink (
        input valid, keyMask, pressed, clearAll
    );

endinterface

// File: common/zxKeyPkg.sv
/*
 * ZX Spectrum keyboard package
 * Matrix types, PS/2 framing constants and the map from
 * scan codes to Spectrum key positions
 */
package zxKeyPkg;

    typedef logic [7:0][4:0] keyMatrix_t;           // 8 rows x 5 keys, 0 = pressed
    typedef logic [4:0]      keyRow_t;              // One row as seen on port FE

    localparam logic [7:0] ScanExtended = 8'hE0;    // Next code is extended
    localparam logic [7:0] ScanRelease  = 8'hF0;    // Next code is a break
    localparam int FrameBits    = 11;               // Start, 8 data, parity, stop
    localparam int FrameTimeout = 2000;             // Idle clk cycles before abandoning
    localparam int SyncStages   = 2;                // Flops on each PS/2 line

    // ==================================================================
    // Scan code to key mask, ones mark the affected keys
    // ==================================================================
    function automatic keyMatrix_t scanToKeys(input logic [7:0] code, input logic extended);
        keyMatrix_t mask;
        mask = '0;
        if (extended) begin
            case (code)
                8'h14: mask[0][0] = 1'b1;                       // Right Ctrl, CAPS
                8'h11: mask[7][1] = 1'b1;                       // Right Alt, SYMBOL
                8'h6B: begin mask[0][0] = 1'b1; mask[3][4] = 1'b1; end  // Left, CAPS+5
                8'h72: begin mask[0][0] = 1'b1; mask[4][4] = 1'b1; end  // Down, CAPS+6
                8'h75: begin mask[0][0] = 1'b1; mask[4][3] = 1'b1; end  // Up, CAPS+7
                8'h74: begin mask[0][0] = 1'b1; mask[4][2] = 1'b1; end  // Right, CAPS+8
                default: mask = '0;                             // Rest of E0 page ignored
            endcase
        end else begin
            case (code)
                8'h12, 8'h59, 8'h14: mask[0][0] = 1'b1;         // Shifts and Ctrl
                8'h1A: mask[0][1] = 1'b1;  8'h22: mask[0][2] = 1'b1;    // Z X
                8'h21: mask[0][3] = 1'b1;  8'h2A: mask[0][4] = 1'b1;    // C V
                8'h1C: mask[1][0] = 1'b1;  8'h1B: mask[1][1] = 1'b1;    // A S
                8'h23: mask[1][2] = 1'b1;  8'h2B: mask[1][3] = 1'b1;    // D F
                8'h34: mask[1][4] = 1'b1;                               // G
                8'h15: mask[2][0] = 1'b1;  8'h1D: mask[2][1] = 1'b1;    // Q W
                8'h24: mask[2][2] = 1'b1;  8'h2D: mask[2][3] = 1'b1;    // E R
                8'h2C: mask[2][4] = 1'b1;                               // T
                8'h16: mask[3][0] = 1'b1;  8'h1E: mask[3][1] = 1'b1;    // 1 2
                8'h26: mask[3][2] = 1'b1;  8'h25: mask[3][3] = 1'b1;    // 3 4
                8'h2E: mask[3][4] = 1'b1;                               // 5
                8'h45: mask[4][0] = 1'b1;  8'h46: mask[4][1] = 1'b1;    // 0 9
                8'h3E: mask[4][2] = 1'b1;  8'h3D: mask[4][3] = 1'b1;    // 8 7
                8'h36: mask[4][4] = 1'b1;                               // 6
                8'h4D: mask[5][0] = 1'b1;  8'h44: mask[5][1] = 1'b1;    // P O
                8'h43: mask[5][2] = 1'b1;  8'h3C: mask[5][3] = 1'b1;    // I U
                8'h35: mask[5][4] = 1'b1;                               // Y
                8'h5A: mask[6][0] = 1'b1;  8'h4B: mask[6][1] = 1'b1;    // ENTER L
                8'h42: mask[6][2] = 1'b1;  8'h3B: mask[6][3] = 1'b1;    // K J
                8'h33: mask[6][4] = 1'b1;                               // H
                8'h29: mask[7][0] = 1'b1;  8'h11: mask[7][1] = 1'b1;    // SPACE SYMBOL
                8'h3A: mask[7][2] = 1'b1;  8'h31: mask[7][3] = 1'b1;    // M N
                8'h32: mask[7][4] = 1'b1;                               // B
                8'h66: begin mask[0][0] = 1'b1; mask[4][0] = 1'b1; end  // Backspace, CAPS+0
                default: mask = '0;                             // Keypad and the rest
            endcase
        end
        return mask;
    endfunction

endpackage
